// File: list.f
+incdir+verilog
verilog/soc_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/lite_demux.sv
verilog/l2_mem.sv
verilog/uart_apb_bridge.sv
verilog/ctrl_regs.sv
verilog/soc_top.sv
test/tb_clock.sv
test/tb_soc.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_soc -f list.f -o tb_soc_sim
	./obj_dir/tb_soc_sim | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_soc.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module tb_soc;

  import soc_bus_pkg::*;

  // Transfers issued by all tests together
  localparam int unsigned NUM_XFERS    = 31;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned CLK_PERIOD   = 4;

  logic        clk;
  logic        reset;
  lite_req_t   bus_req;
  lite_resp_t  bus_resp;
  apb_req_t    apb_req;
  apb_resp_t   apb_resp;
  lite_data_t  exit_val;
  lite_data_t  event_val;
  int unsigned errors;
  int unsigned checks;
  int unsigned apb_count;
  logic [31:0] lcg_state = 32'h3753_b7ea;
  logic [31:0] uart_store [1024];
  logic [31:0] seen_paddr;
  logic [31:0] seen_pwdata;
  logic        seen_pwrite;

  tb_clock i_clock (
    .clk_o  (clk  ),
    .reset_o(reset)
  );

  soc_top soc_top_i (
    .clk_i          (clk      ),
    .reset_i        (reset    ),
    .bus_req_i      (bus_req  ),
    .bus_resp_o     (bus_resp ),
    .uart_apb_o     (apb_req  ),
    .uart_apb_i     (apb_resp ),
    .exit_o         (exit_val ),
    .event_trigger_o(event_val)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected word after a strobed write over old data
  function automatic lite_data_t apply_strobe(lite_data_t old_d, lite_data_t new_d,
                                              lite_strb_t strb);
    lite_data_t mask;
    mask = '0;
    for (int b = 0; b < 8; b++) begin
      mask[b*8 +: 8] = {8{strb[b]}};
    end
    return (new_d & mask) | (old_d & ~mask);
  endfunction

  task automatic compare_value(input string name, input lite_data_t expected,
                               input lite_data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Bus transfers
  ////////////////////////////////////////

  task automatic lite_write(input lite_addr_t addr, input lite_data_t data,
                            input lite_strb_t strb, input int unsigned stall,
                            output lite_resp_e resp);
    bus_req.aw.addr  = addr;
    bus_req.w.data   = data;
    bus_req.w.strb   = strb;
    bus_req.aw_valid = 1'b1;
    bus_req.w_valid  = 1'b1;
    @(negedge clk);
    while (!(bus_resp.aw_ready && bus_resp.w_ready)) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    bus_req.aw_valid = 1'b0;
    bus_req.w_valid  = 1'b0;
    @(negedge clk);
    while (!bus_resp.b_valid) begin
      @(negedge clk);
    end
    resp = bus_resp.b.resp;
    // Response must hold while b_ready stays low
    repeat (stall) begin
      @(negedge clk);
      if (!bus_resp.b_valid) begin
        errors++;
        $display("Write response was withdrawn while b_ready was low");
      end
      compare_value("bus_resp_o.b.resp", 64'(resp), 64'(bus_resp.b.resp));
    end
    @(posedge clk);
    #1;
    bus_req.b_ready = 1'b1;
    @(posedge clk);
    #1;
    bus_req.b_ready = 1'b0;
  endtask

  task automatic lite_read(input lite_addr_t addr, input int unsigned stall,
                           output lite_data_t data, output lite_resp_e resp);
    bus_req.ar.addr  = addr;
    bus_req.ar_valid = 1'b1;
    @(negedge clk);
    while (!bus_resp.ar_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    bus_req.ar_valid = 1'b0;
    @(negedge clk);
    while (!bus_resp.r_valid) begin
      @(negedge clk);
    end
    data = bus_resp.r.data;
    resp = bus_resp.r.resp;
    repeat (stall) begin
      @(negedge clk);
      if (!bus_resp.r_valid) begin
        errors++;
        $display("Read response was withdrawn while r_ready was low");
      end
      compare_value("bus_resp_o.r.data", data, bus_resp.r.data);
      compare_value("bus_resp_o.r.resp", 64'(resp), 64'(bus_resp.r.resp));
    end
    @(posedge clk);
    #1;
    bus_req.r_ready = 1'b1;
    @(posedge clk);
    #1;
    bus_req.r_ready = 1'b0;
  endtask

  // APB subordinate model of the UART with random wait states
  initial begin
    logic [9:0]  idx;
    int unsigned delay;
    apb_resp  = '0;
    apb_count = 0;
    for (int i = 0; i < 1024; i++) begin
      uart_store[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0001_0101);
    end
    forever begin
      @(posedge clk);
      #1;
      if (apb_req.psel === 1'b1 && apb_req.penable === 1'b0) begin
        apb_count++;
        idx         = apb_req.paddr[11:2];
        seen_paddr  = apb_req.paddr;
        seen_pwdata = apb_req.pwdata;
        seen_pwrite = apb_req.pwrite;
        delay       = next_random() % 32'd4;
        repeat (delay + 1) begin
          @(posedge clk);
          #1;
        end
        // Access phase
        compare_value("uart_apb_o.psel", 64'h1, 64'(apb_req.psel));
        compare_value("uart_apb_o.penable", 64'h1, 64'(apb_req.penable));
        if (apb_req.pwrite) begin
          uart_store[idx] = apb_req.pwdata;
        end
        apb_resp.prdata  = uart_store[idx];
        apb_resp.pslverr = apb_req.paddr[11:0] == 12'hFFC;
        apb_resp.pready  = 1'b1;
        @(posedge clk);
        #1;
        apb_resp = '0;
      end
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic after_reset();
    @(negedge clk);
    compare_value("bus_resp_o.b_valid", 64'h0, 64'(bus_resp.b_valid));
    compare_value("bus_resp_o.r_valid", 64'h0, 64'(bus_resp.r_valid));
    compare_value("uart_apb_o.psel", 64'h0, 64'(apb_req.psel));
    compare_value("exit_o", 64'h0, exit_val);
    compare_value("event_trigger_o", 64'h0, event_val);
    @(posedge clk);
    #1;
  endtask

  task automatic l2_write_read();
    lite_addr_t  addr;
    lite_addr_t  addr_b;
    lite_data_t  old_d;
    lite_data_t  new_d;
    lite_data_t  rdata;
    lite_strb_t  strb;
    lite_resp_e  wresp;
    lite_resp_e  rresp;
    logic [31:0] rnd;
    for (int i = 0; i < 4; i++) begin
      addr  = `L2_BASE + 32'(i) * 32'h128;
      old_d = {next_random(), next_random()};
      new_d = {next_random(), next_random()};
      rnd   = next_random();
      strb  = (i == 0) ? 8'hFF : rnd[15:8];
      lite_write(addr, old_d, 8'hFF, 0, wresp);
      lite_write(addr, new_d, strb, 0, wresp);
      compare_value("bus_resp_o.b.resp", 64'(OKAY), 64'(wresp));
      lite_read(addr, 0, rdata, rresp);
      compare_value("bus_resp_o.r.data", apply_strobe(old_d, new_d, strb), rdata);
      compare_value("bus_resp_o.r.resp", 64'(OKAY), 64'(rresp));
    end
    // Write and read in flight together
    addr_b = `L2_BASE + 32'h1FF8;
    fork
      lite_write(addr_b, new_d, 8'hFF, 0, wresp);
      lite_read(addr, 0, rdata, rresp);
    join
    compare_value("bus_resp_o.b.resp", 64'(OKAY), 64'(wresp));
    compare_value("bus_resp_o.r.data", apply_strobe(old_d, new_d, strb), rdata);
    lite_read(addr_b, 0, rdata, rresp);
    compare_value("bus_resp_o.r.data", new_d, rdata);
  endtask

  task automatic ctrl_registers();
    lite_data_t exit_d;
    lite_data_t event_d;
    lite_data_t rdata;
    lite_resp_e resp;
    exit_d  = {next_random(), next_random()};
    event_d = {next_random(), next_random()};
    lite_write(`CTRL_BASE + 32'h0, exit_d, 8'hFF, 0, resp);
    compare_value("bus_resp_o.b.resp", 64'(OKAY), 64'(resp));
    compare_value("exit_o", exit_d, exit_val);
    lite_write(`CTRL_BASE + 32'h8, event_d, 8'hFF, 0, resp);
    compare_value("event_trigger_o", event_d, event_val);
    lite_read(`CTRL_BASE + 32'h0, 0, rdata, resp);
    compare_value("bus_resp_o.r.data", exit_d, rdata);
    lite_read(`CTRL_BASE + 32'h8, 0, rdata, resp);
    compare_value("bus_resp_o.r.data", event_d, rdata);
    // Offset with no register behind it
    lite_write(`CTRL_BASE + 32'h10, ~exit_d, 8'hFF, 0, resp);
    compare_value("bus_resp_o.b.resp", 64'(SLVERR), 64'(resp));
    lite_read(`CTRL_BASE + 32'h10, 0, rdata, resp);
    compare_value("bus_resp_o.r.resp", 64'(SLVERR), 64'(resp));
    compare_value("bus_resp_o.r.data", 64'h0, rdata);
    compare_value("exit_o", exit_d, exit_val);
    compare_value("event_trigger_o", event_d, event_val);
  endtask

  task automatic uart_access();
    lite_data_t wdata;
    lite_data_t rdata;
    lite_resp_e resp;
    wdata = {next_random(), next_random()};
    lite_write(`UART_BASE + 32'h124, wdata, 8'hFF, 0, resp);
    compare_value("bus_resp_o.b.resp", 64'(OKAY), 64'(resp));
    compare_value("uart_apb_o.paddr", 64'h124, 64'(seen_paddr));
    compare_value("uart_apb_o.pwdata", 64'(wdata[31:0]), 64'(seen_pwdata));
    compare_value("uart_apb_o.pwrite", 64'h1, 64'(seen_pwrite));
    lite_read(`UART_BASE + 32'h124, 0, rdata, resp);
    compare_value("bus_resp_o.r.data", {32'h0, wdata[31:0]}, rdata);
    compare_value("bus_resp_o.r.resp", 64'(OKAY), 64'(resp));
    lite_read(`UART_BASE + 32'h040, 0, rdata, resp);
    compare_value("bus_resp_o.r.data", {32'h0, uart_store[10'h010]}, rdata);
    lite_write(`UART_BASE + 32'hFFC, wdata, 8'hFF, 0, resp);
    compare_value("bus_resp_o.b.resp", 64'(SLVERR), 64'(resp));
    lite_read(`UART_BASE + 32'hFFC, 0, rdata, resp);
    compare_value("bus_resp_o.r.resp", 64'(SLVERR), 64'(resp));
  endtask

  task automatic unmapped_access();
    int unsigned count_before;
    lite_data_t  exit_before;
    lite_data_t  event_before;
    lite_data_t  rdata;
    lite_resp_e  resp;
    count_before = apb_count;
    exit_before  = exit_val;
    event_before = event_val;
    lite_write(32'h1000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 8'hFF, 0, resp);
    compare_value("bus_resp_o.b.resp", 64'(DECERR), 64'(resp));
    lite_read(32'h1000_0000, 0, rdata, resp);
    compare_value("bus_resp_o.r.resp", 64'(DECERR), 64'(resp));
    compare_value("bus_resp_o.r.data", 64'h0, rdata);
    if (apb_count != count_before) begin
      errors++;
      $display("An APB transfer followed an access to an unmapped address");
    end
    compare_value("exit_o", exit_before, exit_val);
    compare_value("event_trigger_o", event_before, event_val);
  endtask

  task automatic stalled_responses();
    int unsigned stall;
    lite_data_t  wdata;
    lite_data_t  rdata;
    lite_resp_e  resp;
    wdata = {next_random(), next_random()};
    stall = next_random() % 32'd8 + 32'd2;
    lite_write(`L2_BASE + 32'h40, wdata, 8'hFF, stall, resp);
    compare_value("bus_resp_o.b.resp", 64'(OKAY), 64'(resp));
    stall = next_random() % 32'd8 + 32'd2;
    lite_read(`L2_BASE + 32'h40, stall, rdata, resp);
    compare_value("bus_resp_o.r.data", wdata, rdata);
    stall = next_random() % 32'd8 + 32'd2;
    lite_read(`UART_BASE + 32'h124, stall, rdata, resp);
    compare_value("bus_resp_o.r.data", {32'h0, uart_store[10'h049]}, rdata);
  endtask

  initial begin
    bus_req = '0;
    errors  = 0;
    checks  = 0;
    @(negedge reset);
    after_reset();
    l2_write_read();
    ctrl_registers();
    uart_access();
    unmapped_access();
    stalled_responses();
    $display("errors %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((NUM_XFERS * 64 + RESET_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished, errors %0d", errors);
    $display("sim failed");
    $finish;
  end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  // 4 ns period, reset held for the first 8 rising edges
  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

  always #2 clk_o = ~clk_o;

endmodule

// File: verilog/soc_top.sv
`timescale 1ns/1ps

module soc_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  soc_bus_pkg::lite_req_t  bus_req_i,
  output soc_bus_pkg::lite_resp_t bus_resp_o,
  output soc_bus_pkg::apb_req_t   uart_apb_o,
  input  soc_bus_pkg::apb_resp_t  uart_apb_i,
  output soc_bus_pkg::lite_data_t exit_o,
  output soc_bus_pkg::lite_data_t event_trigger_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  lite_req_t  [NUM_REGIONS-1:0] periph_req;
  lite_resp_t [NUM_REGIONS-1:0] periph_resp;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  lite_demux i_demux (
    .clk_i     (clk_i      ),
    .reset_i   (reset_i    ),
    .mgr_req_i (bus_req_i  ),
    .mgr_resp_o(bus_resp_o ),
    .sub_req_o (periph_req ),
    .sub_resp_i(periph_resp)
  );

  ////////////////////////////////////////
  // Subordinates
  ////////////////////////////////////////

  l2_mem i_l2_mem (
    .clk_i  (clk_i             ),
    .reset_i(reset_i           ),
    .req_i  (periph_req[L2MEM] ),
    .resp_o (periph_resp[L2MEM])
  );

  uart_apb_bridge i_uart_bridge (
    .clk_i  (clk_i            ),
    .reset_i(reset_i          ),
    .req_i  (periph_req[UART] ),
    .resp_o (periph_resp[UART]),
    .apb_o  (uart_apb_o       ),
    .apb_i  (uart_apb_i       )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i          (clk_i            ),
    .reset_i        (reset_i          ),
    .req_i          (periph_req[CTRL] ),
    .resp_o         (periph_resp[CTRL]),
    .exit_o         (exit_o           ),
    .event_trigger_o(event_trigger_o  )
  );

endmodule

// File: verilog/ctrl_regs.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module ctrl_regs (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  soc_bus_pkg::lite_req_t  req_i,
  output soc_bus_pkg::lite_resp_t resp_o,
  output soc_bus_pkg::lite_data_t exit_o,
  output soc_bus_pkg::lite_data_t event_trigger_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int unsigned OFF_BITS = $clog2(`CTRL_LENGTH);

  lite_data_t          exit_q;
  lite_data_t          event_q;
  lite_data_t          rdata_q;
  lite_resp_e          b_resp_q;
  lite_resp_e          r_resp_q;
  logic                b_valid_q;
  logic                r_valid_q;
  logic                wr_en;
  logic                rd_en;
  logic [OFF_BITS-1:0] wr_off;
  logic [OFF_BITS-1:0] rd_off;

  function automatic lite_data_t merge_bytes(lite_data_t old_d, lite_data_t new_d,
                                             lite_strb_t strb);
    lite_data_t res;
    res = old_d;
    for (int i = 0; i < $bits(lite_strb_t); i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_d[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign wr_en  = req_i.aw_valid && req_i.w_valid && !b_valid_q;
  assign rd_en  = req_i.ar_valid && !r_valid_q;
  assign wr_off = req_i.aw.addr[OFF_BITS-1:0];
  assign rd_off = req_i.ar.addr[OFF_BITS-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q    <= '0;
      event_q   <= '0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        b_valid_q <= 1'b1;
        case (wr_off)
          EXIT:    exit_q  <= merge_bytes(exit_q, req_i.w.data, req_i.w.strb);
          EVENT:   event_q <= merge_bytes(event_q, req_i.w.data, req_i.w.strb);
          default: ;
        endcase
      end else if (req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_en) begin
        r_valid_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Response payload, unmapped offsets read as zero
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      b_resp_q <= (wr_off == EXIT || wr_off == EVENT) ? OKAY : SLVERR;
    end
    if (rd_en) begin
      case (rd_off)
        EXIT:    rdata_q <= exit_q;
        EVENT:   rdata_q <= event_q;
        default: rdata_q <= '0;
      endcase
      r_resp_q <= (rd_off == EXIT || rd_off == EVENT) ? OKAY : SLVERR;
    end
  end

  assign exit_o          = exit_q;
  assign event_trigger_o = event_q;

  always_comb begin
    resp_o.aw_ready = !b_valid_q;
    resp_o.w_ready  = !b_valid_q;
    resp_o.b.resp   = b_resp_q;
    resp_o.b_valid  = b_valid_q;
    resp_o.ar_ready = !r_valid_q;
    resp_o.r.data   = rdata_q;
    resp_o.r.resp   = r_resp_q;
    resp_o.r_valid  = r_valid_q;
  end

endmodule

// File: verilog/uart_apb_bridge.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module uart_apb_bridge (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  soc_bus_pkg::lite_req_t  req_i,
  output soc_bus_pkg::lite_resp_t resp_o,
  output soc_bus_pkg::apb_req_t   apb_o,
  input  soc_bus_pkg::apb_resp_t  apb_i
);

  import soc_bus_pkg::*;

  localparam int unsigned OFF_BITS = $clog2(`UART_LENGTH);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS, RESPOND} state_e;

  state_e                     state_q;
  logic                       wr_start;
  logic                       rd_start;
  logic                       resp_hs;
  logic [OFF_BITS-1:0]        start_off;
  logic                       pwrite_q;
  logic                       pslverr_q;
  logic [`APB_ADDR_WIDTH-1:0] paddr_q;
  logic [`APB_DATA_WIDTH-1:0] pwdata_q;
  logic [`APB_DATA_WIDTH-1:0] prdata_q;
  lite_resp_e                 apb_resp;

  // Write takes the APB ahead of a read
  assign wr_start  = state_q == IDLE && req_i.aw_valid && req_i.w_valid;
  assign rd_start  = state_q == IDLE && req_i.ar_valid && !wr_start;
  assign start_off = wr_start ? req_i.aw.addr[OFF_BITS-1:0] : req_i.ar.addr[OFF_BITS-1:0];
  assign resp_hs   = state_q == RESPOND && (pwrite_q ? req_i.b_ready : req_i.r_ready);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (wr_start || rd_start) state_q <= SETUP;
        SETUP:   state_q <= ACCESS;
        ACCESS:  if (apb_i.pready) state_q <= RESPOND;
        RESPOND: if (resp_hs) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_start || rd_start) begin
      pwrite_q <= wr_start;
      paddr_q  <= `APB_ADDR_WIDTH'(start_off);
      pwdata_q <= req_i.w.data[`APB_DATA_WIDTH-1:0];
    end
    // Sample completion on the pready cycle
    if (state_q == ACCESS && apb_i.pready) begin
      prdata_q  <= apb_i.prdata;
      pslverr_q <= apb_i.pslverr;
    end
  end

  assign apb_resp = pslverr_q ? SLVERR : OKAY;

  always_comb begin
    apb_o.paddr     = paddr_q;
    apb_o.psel      = state_q == SETUP || state_q == ACCESS;
    apb_o.penable   = state_q == ACCESS;
    apb_o.pwrite    = pwrite_q;
    apb_o.pwdata    = pwdata_q;
    resp_o.aw_ready = state_q == IDLE;
    resp_o.w_ready  = state_q == IDLE;
    resp_o.b.resp   = apb_resp;
    resp_o.b_valid  = state_q == RESPOND && pwrite_q;
    resp_o.ar_ready = state_q == IDLE && !wr_start;
    resp_o.r.data   = lite_data_t'(prdata_q);
    resp_o.r.resp   = apb_resp;
    resp_o.r_valid  = state_q == RESPOND && !pwrite_q;
  end

endmodule

// File: verilog/l2_mem.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module l2_mem (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  soc_bus_pkg::lite_req_t  req_i,
  output soc_bus_pkg::lite_resp_t resp_o
);

  import soc_bus_pkg::*;

  localparam int unsigned STRB_WIDTH  = `SOC_DATA_WIDTH / 8;
  localparam int unsigned OFFSET_BITS = $clog2(STRB_WIDTH);
  localparam int unsigned INDEX_BITS  = $clog2(`L2_NUM_WORDS);

  lite_data_t            mem_q [`L2_NUM_WORDS];
  lite_data_t            rdata_q;
  logic                  b_valid_q;
  logic                  r_valid_q;
  logic                  wr_en;
  logic                  rd_en;
  logic [INDEX_BITS-1:0] wr_idx;
  logic [INDEX_BITS-1:0] rd_idx;

  assign wr_en  = req_i.aw_valid && req_i.w_valid && !b_valid_q;
  assign rd_en  = req_i.ar_valid && !r_valid_q;
  assign wr_idx = req_i.aw.addr[OFFSET_BITS +: INDEX_BITS];
  assign rd_idx = req_i.ar.addr[OFFSET_BITS +: INDEX_BITS];

  // Byte lanes of the SRAM
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (wr_en && req_i.w.strb[i]) begin
        mem_q[wr_idx][i*8 +: 8] <= req_i.w.data[i*8 +: 8];
      end
    end
  end

  // Read word held until R is taken
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= mem_q[rd_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        b_valid_q <= 1'b1;
      end else if (req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_en) begin
        r_valid_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_comb begin
    resp_o.aw_ready = !b_valid_q;
    resp_o.w_ready  = !b_valid_q;
    resp_o.b.resp   = OKAY;
    resp_o.b_valid  = b_valid_q;
    resp_o.ar_ready = !r_valid_q;
    resp_o.r.data   = rdata_q;
    resp_o.r.resp   = OKAY;
    resp_o.r_valid  = r_valid_q;
  end

endmodule

// File: verilog/lite_demux.sv
`timescale 1ns/1ps

`include "soc_params.svh"

module lite_demux (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  soc_bus_pkg::lite_req_t                                mgr_req_i,
  output soc_bus_pkg::lite_resp_t                               mgr_resp_o,
  output soc_bus_pkg::lite_req_t  [soc_map_pkg::NUM_REGIONS-1:0] sub_req_o,
  input  soc_bus_pkg::lite_resp_t [soc_map_pkg::NUM_REGIONS-1:0] sub_resp_i
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  soc_region_e aw_sel;
  soc_region_e ar_sel;
  soc_region_e w_sel_q;
  soc_region_e r_sel_q;
  logic        w_busy_q;
  logic        r_busy_q;
  logic        aw_hs;
  logic        ar_hs;
  logic        b_hs;
  logic        r_hs;

  function automatic soc_region_e decode(lite_addr_t addr);
    if (addr >= `L2_BASE && addr < `L2_BASE + `L2_LENGTH) begin
      return L2MEM;
    end
    if (addr >= `UART_BASE && addr < `UART_BASE + `UART_LENGTH) begin
      return UART;
    end
    if (addr >= `CTRL_BASE && addr < `CTRL_BASE + `CTRL_LENGTH) begin
      return CTRL;
    end
    return NONE;
  endfunction

  assign aw_sel = decode(mgr_req_i.aw.addr);
  assign ar_sel = decode(mgr_req_i.ar.addr);

  ////////////////////////////////////////
  // Request steering
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_REGIONS; i++) begin
      sub_req_o[i]          = mgr_req_i;
      sub_req_o[i].aw_valid = mgr_req_i.aw_valid && !w_busy_q && aw_sel == soc_region_e'(i);
      sub_req_o[i].w_valid  = mgr_req_i.w_valid && !w_busy_q && aw_sel == soc_region_e'(i);
      sub_req_o[i].b_ready  = mgr_req_i.b_ready && w_busy_q && w_sel_q == soc_region_e'(i);
      sub_req_o[i].ar_valid = mgr_req_i.ar_valid && !r_busy_q && ar_sel == soc_region_e'(i);
      sub_req_o[i].r_ready  = mgr_req_i.r_ready && r_busy_q && r_sel_q == soc_region_e'(i);
    end
  end

  ////////////////////////////////////////
  // Response steering
  ////////////////////////////////////////

  always_comb begin
    mgr_resp_o = '0;
    // Write side, decode misses are answered here
    if (!w_busy_q) begin
      if (aw_sel == NONE) begin
        mgr_resp_o.aw_ready = 1'b1;
        mgr_resp_o.w_ready  = 1'b1;
      end else begin
        mgr_resp_o.aw_ready = sub_resp_i[aw_sel].aw_ready;
        mgr_resp_o.w_ready  = sub_resp_i[aw_sel].w_ready;
      end
    end else if (w_sel_q == NONE) begin
      mgr_resp_o.b_valid = 1'b1;
      mgr_resp_o.b.resp  = DECERR;
    end else begin
      mgr_resp_o.b       = sub_resp_i[w_sel_q].b;
      mgr_resp_o.b_valid = sub_resp_i[w_sel_q].b_valid;
    end
    // Read side
    if (!r_busy_q) begin
      mgr_resp_o.ar_ready = (ar_sel == NONE) ? 1'b1 : sub_resp_i[ar_sel].ar_ready;
    end else if (r_sel_q == NONE) begin
      mgr_resp_o.r_valid = 1'b1;
      mgr_resp_o.r.resp  = DECERR;
    end else begin
      mgr_resp_o.r       = sub_resp_i[r_sel_q].r;
      mgr_resp_o.r_valid = sub_resp_i[r_sel_q].r_valid;
    end
  end

  assign aw_hs = mgr_req_i.aw_valid && mgr_resp_o.aw_ready;
  assign ar_hs = mgr_req_i.ar_valid && mgr_resp_o.ar_ready;
  assign b_hs  = mgr_resp_o.b_valid && mgr_req_i.b_ready;
  assign r_hs  = mgr_resp_o.r_valid && mgr_req_i.r_ready;

  // One outstanding transfer per direction
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      w_busy_q <= 1'b0;
      r_busy_q <= 1'b0;
      w_sel_q  <= NONE;
      r_sel_q  <= NONE;
    end else begin
      if (aw_hs) begin
        w_busy_q <= 1'b1;
        w_sel_q  <= aw_sel;
      end else if (b_hs) begin
        w_busy_q <= 1'b0;
      end
      if (ar_hs) begin
        r_busy_q <= 1'b1;
        r_sel_q  <= ar_sel;
      end else if (r_hs) begin
        r_busy_q <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/soc_map_pkg.sv
package soc_map_pkg;

  `include "soc_params.svh"

  // Mapped regions first, NONE marks a decode miss
  typedef enum logic [1:0] {
    L2MEM = 2'd0,
    UART  = 2'd1,
    CTRL  = 2'd2,
    NONE  = 2'd3
  } soc_region_e;

  localparam int unsigned NUM_REGIONS = NONE;

  // Offsets inside the control region
  typedef enum logic [$clog2(`CTRL_LENGTH)-1:0] {
    EXIT  = 'h0,
    EVENT = 'h8
  } ctrl_reg_e;

endpackage

// File: verilog/soc_bus_pkg.sv
package soc_bus_pkg;

  `include "soc_params.svh"

  typedef logic [`SOC_ADDR_WIDTH-1:0]   lite_addr_t;
  typedef logic [`SOC_DATA_WIDTH-1:0]   lite_data_t;
  typedef logic [`SOC_DATA_WIDTH/8-1:0] lite_strb_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } lite_resp_e;

  typedef struct packed { lite_addr_t addr; } lite_aw_t;
  typedef struct packed { lite_addr_t addr; } lite_ar_t;
  typedef struct packed { lite_data_t data; lite_strb_t strb; } lite_w_t;
  typedef struct packed { lite_resp_e resp; } lite_b_t;
  typedef struct packed { lite_data_t data; lite_resp_e resp; } lite_r_t;

  // Manager side of the AXI4-Lite bus
  typedef struct packed {
    lite_aw_t aw;
    logic     aw_valid;
    lite_w_t  w;
    logic     w_valid;
    logic     b_ready;
    lite_ar_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    lite_b_t b;
    logic    b_valid;
    logic    ar_ready;
    lite_r_t r;
    logic    r_valid;
  } lite_resp_t;

  typedef struct packed {
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pready;
    logic                       pslverr;
  } apb_resp_t;

endpackage

// File: verilog/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 64

// UART APB port
`define APB_ADDR_WIDTH 32
`define APB_DATA_WIDTH 32

// L2 depth in 64-bit words
`define L2_NUM_WORDS 1024

// Memory map
`define L2_BASE     32'h8000_0000
`define L2_LENGTH   32'h0000_2000
`define UART_BASE   32'hC000_0000
`define UART_LENGTH 32'h0000_1000
`define CTRL_BASE   32'hD000_0000
`define CTRL_LENGTH 32'h0000_1000

`endif
